// File: logic/gat_params.svh
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// Data path widths
`define GAT_DATA_W       8
`define GAT_ACC_W        20
`define GAT_WH_W         12
`define GAT_ENTRY_W      16

// Matrix sizes
`define GAT_NUM_FEAT_IN  16
`define GAT_NUM_FEAT_OUT 4
`define GAT_IDX_W        4
`define GAT_LANE_W       2
`define GAT_ROW_W        8

`endif

// File: logic/gat_pkg.sv
`include "gat_params.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_t;

  // Weight load: lane selects the W column, row the W row
  typedef struct packed {
    logic [1:0]             pad;
    logic [`GAT_LANE_W-1:0] lane;
    logic [`GAT_IDX_W-1:0]  row;
    data_t                  value;
  } wgt_word_t;

  // Nonzero H entry
  typedef struct packed {
    logic [3:0]            pad;
    logic [`GAT_IDX_W-1:0] col;
    data_t                 value;
  } nz_word_t;

  // Same input word, view picked by load_wgt_i
  typedef union packed {
    wgt_word_t wgt;
    nz_word_t  nz;
  } entry_u;

endpackage

// File: logic/entry_bus_if.sv
`include "gat_params.svh"

interface entry_bus_if;
  import gat_pkg::*;

  logic                   nz_vld;
  logic                   wgt_we;
  logic [`GAT_LANE_W-1:0] wgt_lane;
  // W row on a weight write, H column on an entry
  logic [`GAT_IDX_W-1:0]  idx;
  data_t                  value;
  logic                   last;

  modport decoder (
    output nz_vld, wgt_we, wgt_lane, idx, value, last
  );

  modport lane (
    input nz_vld, wgt_we, wgt_lane, idx, value, last
  );

endinterface

// File: logic/entry_decoder.sv
`include "gat_params.svh"

module entry_decoder (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            entry_vld_i,
  input  logic            load_wgt_i,
  input  logic            entry_last_i,
  input  gat_pkg::entry_u entry_i,
  entry_bus_if.decoder    bus
);
  import gat_pkg::*;

  entry_u word_q;
  logic   vld_q;
  logic   wgt_q;
  logic   last_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      wgt_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= entry_vld_i;
      wgt_q  <= load_wgt_i;
      last_q <= entry_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (entry_vld_i) begin
      word_q <= entry_i;
    end
  end

  // Strobes last exactly one cycle after the sampling edge
  assign bus.nz_vld   = vld_q & ~wgt_q;
  assign bus.wgt_we   = vld_q & wgt_q;
  assign bus.last     = vld_q & ~wgt_q & last_q;
  assign bus.wgt_lane = word_q.wgt.lane;
  // W row and H column sit in the same bits of both views
  assign bus.idx      = word_q.nz.col;
  assign bus.value    = word_q.nz.value;

  // Row end marker only belongs to an H entry
  a_no_last_on_wgt: assert property (
    @(posedge clk) disable iff (!rst_n)
    entry_vld_i |-> !(entry_last_i && load_wgt_i)
  );

endmodule

// File: logic/mac_lane.sv
`include "gat_params.svh"

module mac_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`GAT_LANE_W-1:0] lane_id_i,
  entry_bus_if.lane              bus,
  output gat_pkg::acc_t          sum_o,
  output logic                   done_o
);
  import gat_pkg::*;

  data_t                          w_col [`GAT_NUM_FEAT_IN];
  acc_t                           acc_q;
  acc_t                           acc_nxt;
  acc_t                           sum_q;
  logic                           done_q;
  logic signed [2*`GAT_DATA_W-1:0] prod;

  // One column of W, indexed by the H column of the entry
  assign prod    = bus.value * w_col[bus.idx];
  assign acc_nxt = acc_q + acc_t'(prod);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `GAT_NUM_FEAT_IN; r++) begin
        w_col[r] <= '0;
      end
    end else if (bus.wgt_we && (bus.wgt_lane == lane_id_i)) begin
      w_col[bus.idx] <= bus.value;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= bus.nz_vld & bus.last;
      if (bus.nz_vld) begin
        // Restart from zero so the next row can follow back to back
        acc_q <= bus.last ? '0 : acc_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.nz_vld && bus.last) begin
      sum_q <= acc_nxt;
    end
  end

  assign sum_o  = sum_q;
  assign done_o = done_q;

  a_one_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(bus.nz_vld && bus.wgt_we)
  );

endmodule

// File: logic/wh_packer.sv
`include "gat_params.svh"

module wh_packer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  gat_pkg::acc_t                           lane_sum_i [`GAT_NUM_FEAT_OUT],
  input  logic [`GAT_NUM_FEAT_OUT-1:0]            lane_done_i,
  output logic                                    wh_vld_o,
  output logic [`GAT_ROW_W-1:0]                   wh_row_o,
  output gat_pkg::wh_t [`GAT_NUM_FEAT_OUT-1:0]    wh_data_o
);
  import gat_pkg::*;

  localparam acc_t WH_MAX = acc_t'(2 ** (`GAT_WH_W - 1) - 1);
  localparam acc_t WH_MIN = -WH_MAX - acc_t'(1);

  wh_t [`GAT_NUM_FEAT_OUT-1:0] clip_c;
  logic [`GAT_ROW_W-1:0]       row_q;
  logic                        done_c;

  function automatic wh_t clip_sum(input acc_t s);
    acc_t lim;
    if (s > WH_MAX) begin
      lim = WH_MAX;
    end else if (s < WH_MIN) begin
      lim = WH_MIN;
    end else begin
      lim = s;
    end
    return wh_t'(lim);
  endfunction

  always_comb begin
    for (int l = 0; l < `GAT_NUM_FEAT_OUT; l++) begin
      clip_c[l] = clip_sum(lane_sum_i[l]);
    end
  end

  // All lanes finish a row together
  assign done_c = |lane_done_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
      row_q    <= '0;
    end else begin
      wh_vld_o <= done_c;
      if (done_c) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done_c) begin
      wh_data_o <= clip_c;
      wh_row_o  <= row_q;
    end
  end

  a_lanes_in_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    (lane_done_i == '0) || (&lane_done_i)
  );

endmodule

// File: logic/gat_spmm_top.sv
`include "gat_params.svh"

module gat_spmm_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 entry_vld_i,
  input  logic                                 load_wgt_i,
  input  logic                                 entry_last_i,
  input  gat_pkg::entry_u                      entry_i,
  output logic                                 wh_vld_o,
  output logic [`GAT_ROW_W-1:0]                wh_row_o,
  output gat_pkg::wh_t [`GAT_NUM_FEAT_OUT-1:0] wh_data_o
);
  import gat_pkg::*;

  acc_t                        lane_sum  [`GAT_NUM_FEAT_OUT];
  logic [`GAT_NUM_FEAT_OUT-1:0] lane_done;

  entry_bus_if bus_if ();

  entry_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .entry_vld_i  (entry_vld_i),
    .load_wgt_i   (load_wgt_i),
    .entry_last_i (entry_last_i),
    .entry_i      (entry_i),
    .bus          (bus_if.decoder)
  );

  // One lane per output feature, each owning a W column
  for (genvar g = 0; g < `GAT_NUM_FEAT_OUT; g++) begin : g_lane
    mac_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .lane_id_i (`GAT_LANE_W'(g)),
      .bus       (bus_if.lane),
      .sum_o     (lane_sum[g]),
      .done_o    (lane_done[g])
    );
  end

  wh_packer u_packer (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_sum_i  (lane_sum),
    .lane_done_i (lane_done),
    .wh_vld_o    (wh_vld_o),
    .wh_row_o    (wh_row_o),
    .wh_data_o   (wh_data_o)
  );

endmodule

// File: dv/tb_gat_spmm.sv
`include "gat_params.svh"

module tb_gat_spmm;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_WGT  = 2'd1;
  localparam logic [1:0] OP_NZ   = 2'd2;

  typedef struct packed {
    logic [1:0]                               kind;
    logic [`GAT_LANE_W-1:0]                   lane;
    logic [`GAT_IDX_W-1:0]                    idx;
    logic [`GAT_DATA_W-1:0]                   value;
    logic                                     last;
    logic [`GAT_ROW_W-1:0]                    exp_row;
    logic [`GAT_NUM_FEAT_OUT*`GAT_WH_W-1:0]   exp_data;
  } op_t;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic                                 entry_vld_i;
  logic                                 load_wgt_i;
  logic                                 entry_last_i;
  gat_pkg::entry_u                      entry_i;
  logic                                 wh_vld_o;
  logic [`GAT_ROW_W-1:0]                wh_row_o;
  gat_pkg::wh_t [`GAT_NUM_FEAT_OUT-1:0] wh_data_o;

  // Stimulus table with the expected row on each last entry
  op_t   ops [$];
  string op_name [$];

  // Results still owed by the DUT
  logic [`GAT_NUM_FEAT_OUT*`GAT_WH_W-1:0] exp_data_q [$];
  logic [`GAT_ROW_W-1:0]                  exp_row_q [$];
  int                                     exp_due_q [$];
  string                                  exp_name_q [$];

  // Reference model state
  int                    w_ref [`GAT_NUM_FEAT_IN][`GAT_NUM_FEAT_OUT];
  int                    acc_ref [`GAT_NUM_FEAT_OUT];
  logic [`GAT_ROW_W-1:0] row_ref = '0;

  logic [15:0] lfsr = 16'd89;
  int          cyc = 0;
  int          cyc_limit = 1000;
  string       mon_name;

  gat_spmm_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .entry_vld_i  (entry_vld_i),
    .load_wgt_i   (load_wgt_i),
    .entry_last_i (entry_last_i),
    .entry_i      (entry_i),
    .wh_vld_o     (wh_vld_o),
    .wh_row_o     (wh_row_o),
    .wh_data_o    (wh_data_o)
  );

  always #5 clk = ~clk;

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_fail($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic int clip_wh(input int s);
    int r;
    r = s;
    if (s > 2047) begin
      r = 2047;
    end else if (s < -2048) begin
      r = -2048;
    end
    return r;
  endfunction

  task automatic add_idle(input string name, input int n);
    op_t op;
    op = '0;
    op.kind = OP_IDLE;
    for (int i = 0; i < n; i++) begin
      ops.push_back(op);
      op_name.push_back(name);
    end
  endtask

  task automatic add_weight(input string name, input int lane, input int row, input int value);
    op_t op;
    op = '0;
    op.kind  = OP_WGT;
    op.lane  = lane[`GAT_LANE_W-1:0];
    op.idx   = row[`GAT_IDX_W-1:0];
    op.value = value[`GAT_DATA_W-1:0];
    w_ref[row][lane] = value;
    ops.push_back(op);
    op_name.push_back(name);
  endtask

  task automatic add_entry(input string name, input int col, input int value, input bit last);
    op_t op;
    int  clipped;
    op = '0;
    op.kind  = OP_NZ;
    op.idx   = col[`GAT_IDX_W-1:0];
    op.value = value[`GAT_DATA_W-1:0];
    op.last  = last;
    for (int l = 0; l < `GAT_NUM_FEAT_OUT; l++) begin
      acc_ref[l] += value * w_ref[col][l];
    end
    if (last) begin
      // Lane 0 sits in the lowest bits
      for (int l = 0; l < `GAT_NUM_FEAT_OUT; l++) begin
        clipped = clip_wh(acc_ref[l]);
        op.exp_data[l*`GAT_WH_W +: `GAT_WH_W] = clipped[`GAT_WH_W-1:0];
        acc_ref[l] = 0;
      end
      op.exp_row = row_ref;
      row_ref = row_ref + 8'd1;
    end
    ops.push_back(op);
    op_name.push_back(name);
  endtask

  task automatic build_table();
    logic [7:0] b;
    add_idle("idle after reset", 4);
    for (int r = 0; r < `GAT_NUM_FEAT_IN; r++) begin
      for (int l = 0; l < `GAT_NUM_FEAT_OUT; l++) begin
        rand_byte(b);
        add_weight("weight load", l, r, $signed(b));
      end
    end
    add_entry("single entry", 3, 5, 1'b1);
    add_idle("gap", 2);
    add_entry("single entry top col", 15, -7, 1'b1);
    add_entry("zero row", 0, 0, 1'b1);
    add_entry("multi entry", 0, 12, 1'b0);
    add_entry("multi entry", 5, -3, 1'b0);
    add_entry("multi entry", 9, 100, 1'b0);
    add_entry("multi entry", 12, -77, 1'b1);
    // Rows follow each other with no gap
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < 3 + k; c++) begin
        rand_byte(b);
        add_entry("back to back", (c * 5 + k) % 16, $signed(b), c == 2 + k);
      end
    end
    add_idle("gap", 3);
    add_weight("rewrite", 2, 4, -100);
    add_entry("after rewrite", 4, 9, 1'b0);
    add_entry("after rewrite", 7, -2, 1'b1);
    add_entry("col not rewritten", 6, 11, 1'b1);
    for (int r = 0; r < `GAT_NUM_FEAT_IN; r++) begin
      add_weight("clip weights", 0, r, 127);
      add_weight("clip weights", 1, r, -128);
      add_weight("clip weights", 2, r, 1);
      add_weight("clip weights", 3, r, 0);
    end
    for (int c = 0; c < `GAT_NUM_FEAT_IN; c++) begin
      add_entry("clip high", c, 127, c == `GAT_NUM_FEAT_IN - 1);
    end
    for (int c = 0; c < `GAT_NUM_FEAT_IN; c++) begin
      add_entry("clip low", c, -128, c == `GAT_NUM_FEAT_IN - 1);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit) begin
      stop_fail($sformatf("Timeout after %0d cycles with rows still pending", cyc));
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && wh_vld_o === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        stop_fail("wh_vld_o pulsed with no row outstanding");
      end else begin
        mon_name = exp_name_q.pop_front();
        check_value({mon_name, " cycle"}, exp_due_q.pop_front(), cyc);
        check_value({mon_name, " row"}, exp_row_q.pop_front(), wh_row_o);
        check_value({mon_name, " data"}, exp_data_q.pop_front(), wh_data_o);
      end
    end else if (exp_due_q.size() != 0 && cyc > exp_due_q[0]) begin
      stop_fail({"No wh_vld_o pulse for row of ", exp_name_q[0]});
    end
  end

  initial begin
    op_t op;
    rst_n        = 1'b0;
    entry_vld_i  = 1'b0;
    load_wgt_i   = 1'b0;
    entry_last_i = 1'b0;
    entry_i      = '0;
    build_table();
    cyc_limit = ops.size() + 50;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < ops.size(); i++) begin
      op = ops[i];
      entry_vld_i  = (op.kind != OP_IDLE);
      load_wgt_i   = (op.kind == OP_WGT);
      entry_last_i = (op.kind == OP_NZ) && op.last;
      entry_i      = '0;
      if (op.kind == OP_WGT) begin
        entry_i.wgt.lane  = op.lane;
        entry_i.wgt.row   = op.idx;
        entry_i.wgt.value = op.value;
      end else begin
        entry_i.nz.col   = op.idx;
        entry_i.nz.value = op.value;
      end
      if (entry_last_i) begin
        // Seen by a consumer on the third edge after this entry is sampled
        exp_data_q.push_back(op.exp_data);
        exp_row_q.push_back(op.exp_row);
        exp_due_q.push_back(cyc + 3);
        exp_name_q.push_back(op_name[i]);
      end
      @(posedge clk);
      #1;
    end
    entry_vld_i  = 1'b0;
    load_wgt_i   = 1'b0;
    entry_last_i = 1'b0;
    // Last row is due three edges after its entry is sampled
    repeat (3) @(posedge clk);
    if (exp_data_q.size() != 0) begin
      stop_fail("Rows still outstanding at the end of the run");
    end else begin
      repeat (4) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+logic
logic/gat_pkg.sv
logic/entry_bus_if.sv
logic/entry_decoder.sv
logic/mac_lane.sv
logic/wh_packer.sv
logic/gat_spmm_top.sv
dv/tb_gat_spmm.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_gat_spmm -o sim_tb
	@out=$$(./obj_dir/sim_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
